// ==== Bender.yml ====
package:
  name: xt_glue

export_include_dirs:
  - logic

sources:
  - files:
      - logic/xt_bus_pkg.sv
      - logic/xt_decode_pkg.sv
      - logic/cycle_intake.sv
      - logic/address_decoder.sv
      - logic/system_ctrl.sv
      - logic/response_stage.sv
      - logic/xt_glue_top.sv
  - target: simulation
    files:
      - sim/xt_glue_tb.sv

// ==== logic/address_decoder.sv ====
// address_decoder: i/o block, rom slot and ram bank selects
// for the cycle in the intake slot

`include "xt_glue_defs.svh"

module address_decoder (
   input  xt_bus_pkg::bus_req_t    req_i,
   output xt_decode_pkg::io_sel_t  io_sel_o,
   output xt_decode_pkg::rom_sel_t rom_sel_o,
   output xt_decode_pkg::ram_sel_t ram_sel_o
);

   import xt_bus_pkg::*;

   addr_t     a;
   cyc_kind_t kind;

   logic io_cyc;
   logic mem_cyc;
   logic io_low;    // port below 0x100
   logic rom_area;  // top 64 KB
   logic ram_area;  // lower 256 KB

   assign a    = req_i.addr;
   assign kind = req_i.kind;

   assign io_cyc  = (kind == `XT_CYC_IOR) || (kind == `XT_CYC_IOW);
   assign mem_cyc = (kind == `XT_CYC_MEMR) || (kind == `XT_CYC_MEMW);

   assign io_low   = (a[9:8] == 2'b00);
   assign rom_area = (a[19:16] == 4'hF);
   assign ram_area = (a[19:18] == 2'b00);

   // peripheral blocks, 32 bytes each
   always_comb begin
      io_sel_o = '0;
      if (io_cyc && io_low) begin
         io_sel_o[a[7:5]] = 1'b1;
      end
   end

   // rom answers reads only
   always_comb begin
      rom_sel_o = '0;
      if ((kind == `XT_CYC_MEMR) && rom_area) begin
         rom_sel_o[a[15:13]] = 1'b1;
      end
   end

   // ram banks take reads and writes
   always_comb begin
      ram_sel_o = '0;
      if (mem_cyc && ram_area) begin
         ram_sel_o[a[17:16]] = 1'b1;
      end
   end

endmodule

// ==== logic/cycle_intake.sv ====
// cycle_intake: one-deep input register for bus cycles

module cycle_intake (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 req_valid_i,
   input  xt_bus_pkg::bus_req_t req_i,
   output logic                 req_ready_o,
   output logic                 slot_valid_o,
   output xt_bus_pkg::bus_req_t slot_req_o,
   input  logic                 slot_ready_i
);

   import xt_bus_pkg::*;

   logic     valid_q;  // slot holds a cycle
   bus_req_t req_q;    // held cycle

   // free now, or the held cycle leaves on this edge
   assign req_ready_o = !valid_q || slot_ready_i;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         valid_q <= 1'b0;
      end else if (req_ready_o) begin
         valid_q <= req_valid_i;  // refill or drain
      end
   end

   // payload, loaded only on an input transfer
   always_ff @(posedge clk) begin
      if (req_valid_i && req_ready_o) begin
         req_q <= req_i;
      end
   end

   assign slot_valid_o = valid_q;
   assign slot_req_o   = req_q;

endmodule

// ==== logic/response_stage.sv ====
// response_stage: output register for one response

module response_stage (
   input  logic                    clk,
   input  logic                    reset_n,
   input  logic                    fire_i,
   input  xt_decode_pkg::bus_rsp_t rsp_i,
   output logic                    slot_ready_o,
   output logic                    rsp_valid_o,
   output xt_decode_pkg::bus_rsp_t rsp_o,
   input  logic                    rsp_ready_i
);

   import xt_decode_pkg::*;

   logic     valid_q;
   bus_rsp_t rsp_q;  // held response

   // empty, or emptying on this edge
   assign slot_ready_o = !valid_q || rsp_ready_i;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         valid_q <= 1'b0;
      end else if (fire_i) begin
         valid_q <= 1'b1;  // new response replaces a taken one
      end else if (rsp_ready_i) begin
         valid_q <= 1'b0;
      end
   end

   // payload, no reset
   always_ff @(posedge clk) begin
      if (fire_i) begin
         rsp_q <= rsp_i;
      end
   end

   assign rsp_valid_o = valid_q;
   assign rsp_o       = rsp_q;

endmodule

// ==== logic/system_ctrl.sv ====
// system_ctrl: control port, status port, nmi mask and error latches
// drives timer-2 gate, speaker and nmi

`include "xt_glue_defs.svh"

module system_ctrl (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 fire_i,
   input  xt_bus_pkg::bus_req_t req_i,
   input  logic                 parity_err_i,
   input  logic                 io_ch_ck_i,
   input  logic                 timer2_out_i,
   output logic                 hit_o,
   output xt_bus_pkg::data_t    rdata_o,
   output logic                 tim2_gate_o,
   output logic                 spkr_o,
   output logic                 nmi_o
);

   import xt_bus_pkg::*;
   import xt_decode_pkg::*;

   ctrl_reg_t ctrl_q;       // port 0x61
   ctrl_reg_t ctrl_d;       // value after this edge
   logic      allow_nmi_q;  // 0xA0 bit 7
   logic      par_err_q;    // latched parity error
   logic      chk_err_q;    // latched channel check

   logic is_ior;
   logic is_iow;
   logic sel_ctrl;
   logic sel_stat;
   logic sel_nmi;
   logic wr_ctrl;
   logic wr_nmi;

   // own port decode, full address
   assign is_ior   = (req_i.kind == `XT_CYC_IOR);
   assign is_iow   = (req_i.kind == `XT_CYC_IOW);
   assign sel_ctrl = (req_i.addr == `XT_PORT_CTRL);
   assign sel_stat = (req_i.addr == `XT_PORT_STAT);
   assign sel_nmi  = (req_i.addr == `XT_PORT_NMI);

   assign hit_o = (is_ior || is_iow) && (sel_ctrl || sel_stat || sel_nmi);

   assign wr_ctrl = fire_i && is_iow && sel_ctrl;
   assign wr_nmi  = fire_i && is_iow && sel_nmi;  // status port is read only

   // enables seen by the latches at this edge
   assign ctrl_d = wr_ctrl ? req_i.wdata : ctrl_q;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ctrl_q      <= '0;
         allow_nmi_q <= 1'b0;
      end else begin
         if (wr_ctrl) ctrl_q <= req_i.wdata;
         if (wr_nmi) allow_nmi_q <= req_i.wdata[7];
      end
   end

   // error latches, held clear while the enable bit is high
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         par_err_q <= 1'b0;
         chk_err_q <= 1'b0;
      end else begin
         if (ctrl_d[4]) par_err_q <= 1'b0;
         else if (parity_err_i) par_err_q <= 1'b1;

         if (ctrl_d[5]) chk_err_q <= 1'b0;
         else if (io_ch_ck_i) chk_err_q <= 1'b1;
      end
   end

   // read data, register values before the edge
   always_comb begin
      rdata_o = '0;
      if (is_ior) begin
         if (sel_ctrl) rdata_o = ctrl_q;
         else if (sel_stat) rdata_o = {par_err_q, chk_err_q, timer2_out_i, 5'b0};
         else if (sel_nmi) rdata_o = {allow_nmi_q, 7'b0};
      end
   end

   assign tim2_gate_o = ctrl_q[0];
   assign spkr_o      = timer2_out_i & ctrl_q[1];  // gated speaker
   assign nmi_o       = allow_nmi_q & (par_err_q | chk_err_q);

endmodule

// ==== logic/xt_bus_pkg.sv ====
// bus-side types: address, data byte, cycle kind
// and the request struct

`include "xt_glue_defs.svh"

package xt_bus_pkg;

   // 20-bit bus address
   typedef logic [`XT_ADDR_W-1:0] addr_t;

   // one data byte
   typedef logic [`XT_DATA_W-1:0] data_t;

   // ior, iow, memr or memw
   typedef logic [1:0] cyc_kind_t;

   // one bus cycle, 30 bits
   typedef struct packed {
      cyc_kind_t kind;   // cycle code
      addr_t     addr;
      data_t     wdata;  // ignored on reads
   } bus_req_t;

endpackage

// ==== logic/xt_decode_pkg.sv ====
// select and register types, response struct

`include "xt_glue_defs.svh"

package xt_decode_pkg;

   // one-hot peripheral block select, a[7:5]
   typedef logic [`XT_IO_BLOCKS-1:0] io_sel_t;

   // one-hot rom slot select, a[15:13]
   typedef logic [`XT_ROM_SLOTS-1:0] rom_sel_t;

   // one-hot ram bank select, a[17:16]
   typedef logic [`XT_RAM_BANKS-1:0] ram_sel_t;

   // system control port at 0x61
   // bit 0 timer-2 gate, bit 1 speaker data,
   // bit 4 parity check enable (low), bit 5 i/o check enable (low)
   typedef logic [`XT_DATA_W-1:0] ctrl_reg_t;

   // one response per bus cycle, 29 bits
   typedef struct packed {
      io_sel_t           io_sel;
      rom_sel_t          rom_sel;
      ram_sel_t          ram_sel;
      logic              hit;    // board register addressed
      xt_bus_pkg::data_t rdata;  // board register read data
   } bus_rsp_t;

endpackage

// ==== logic/xt_glue_defs.svh ====
// bus widths, cycle codes, board port numbers
// and decode sizes for the system board glue

`ifndef XT_GLUE_DEFS_SVH
`define XT_GLUE_DEFS_SVH

// bus widths
`define XT_ADDR_W 20
`define XT_DATA_W 8

// cycle kinds, as carried in the request
`define XT_CYC_IOR  2'b00
`define XT_CYC_IOW  2'b01
`define XT_CYC_MEMR 2'b10
`define XT_CYC_MEMW 2'b11

// board ports, full 20-bit address
`define XT_PORT_CTRL 20'h00061  // system control port
`define XT_PORT_STAT 20'h00062  // status port
`define XT_PORT_NMI  20'h000A0  // nmi mask register

// decode sizes
// i/o space below 0x100 in 32-byte blocks
`define XT_IO_BLOCKS 8
// 8 KB rom slots in the top 64 KB
`define XT_ROM_SLOTS 8
// 64 KB ram banks in the lower 256 KB
`define XT_RAM_BANKS 4

`endif

// ==== logic/xt_glue_top.sv ====
// xt_glue_top: bus-cycle slave for the system board glue
// intake, decode and board registers, response register

module xt_glue_top (
   input  logic                    clk,
   input  logic                    reset_n,
   input  logic                    req_valid_i,
   input  xt_bus_pkg::bus_req_t    req_i,
   output logic                    req_ready_o,
   output logic                    rsp_valid_o,
   output xt_decode_pkg::bus_rsp_t rsp_o,
   input  logic                    rsp_ready_i,
   input  logic                    parity_err_i,
   input  logic                    io_ch_ck_i,
   input  logic                    timer2_out_i,
   output logic                    tim2_gate_o,
   output logic                    spkr_o,
   output logic                    nmi_o
);

   import xt_bus_pkg::*;
   import xt_decode_pkg::*;

   logic     slot_valid;
   logic     slot_ready;
   bus_req_t slot_req;
   logic     fire;  // cycle moves from intake to response

   io_sel_t  io_sel;
   rom_sel_t rom_sel;
   ram_sel_t ram_sel;
   logic     hit;
   data_t    rdata;
   bus_rsp_t rsp_d;  // merged response

   assign fire = slot_valid & slot_ready;

   cycle_intake cycle_intake_inst (
      .clk          (clk),
      .reset_n      (reset_n),
      .req_valid_i  (req_valid_i),
      .req_i        (req_i),
      .req_ready_o  (req_ready_o),
      .slot_valid_o (slot_valid),
      .slot_req_o   (slot_req),
      .slot_ready_i (slot_ready)
   );

   address_decoder address_decoder_inst (
      .req_i     (slot_req),
      .io_sel_o  (io_sel),
      .rom_sel_o (rom_sel),
      .ram_sel_o (ram_sel)
   );

   system_ctrl system_ctrl_inst (
      .clk          (clk),
      .reset_n      (reset_n),
      .fire_i       (fire),
      .req_i        (slot_req),
      .parity_err_i (parity_err_i),
      .io_ch_ck_i   (io_ch_ck_i),
      .timer2_out_i (timer2_out_i),
      .hit_o        (hit),
      .rdata_o      (rdata),
      .tim2_gate_o  (tim2_gate_o),
      .spkr_o       (spkr_o),
      .nmi_o        (nmi_o)
   );

   // decode selects plus board register answer
   always_comb begin
      rsp_d.io_sel  = io_sel;
      rsp_d.rom_sel = rom_sel;
      rsp_d.ram_sel = ram_sel;
      rsp_d.hit     = hit;
      rsp_d.rdata   = rdata;
   end

   response_stage response_stage_inst (
      .clk          (clk),
      .reset_n      (reset_n),
      .fire_i       (fire),
      .rsp_i        (rsp_d),
      .slot_ready_o (slot_ready),
      .rsp_valid_o  (rsp_valid_o),
      .rsp_o        (rsp_o),
      .rsp_ready_i  (rsp_ready_i)
   );

endmodule

// ==== sim/xt_glue_tb.sv ====
// board glue testbench with clock, reset, stimulus,
// reference model and response assertions

`include "xt_glue_defs.svh"

module xt_glue_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import xt_bus_pkg::*;
   import xt_decode_pkg::*;

   localparam int DRIVE_DLY = 10;   // after the rising edge
   localparam int TIMEOUT   = 200;  // cycles per wait

   logic     clk;
   logic     reset_n;
   logic     req_valid_i;
   bus_req_t req_i;
   logic     req_ready_o;
   logic     rsp_valid_o;
   bus_rsp_t rsp_o;
   logic     rsp_ready_i;
   logic     parity_err_i;
   logic     io_ch_ck_i;
   logic     timer2_out_i;
   logic     tim2_gate_o;
   logic     spkr_o;
   logic     nmi_o;

   integer seed = 32'h16fe7490;
   int     errors;
   int     timeouts;
   int     acc_count;
   int     rsp_count;
   logic   bp_on;  // random rsp_ready_i

   // reference model advanced in request order
   ctrl_reg_t m_ctrl;
   logic      m_allow;
   logic      m_par;
   logic      m_chk;
   bus_rsp_t  exp_q[$];
   bus_rsp_t  exp_head;
   int        exp_count;
   bus_rsp_t  last_rsp;

   xt_glue_top xt_glue_top_inst (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // expected response from the decode and register rules
   function automatic bus_rsp_t predict_response(input bus_req_t r);
      bus_rsp_t e;
      logic     io;
      e  = '0;
      io = (r.kind == `XT_CYC_IOR) || (r.kind == `XT_CYC_IOW);
      if (io && r.addr[9:8] == 2'b00) e.io_sel = 8'h01 << r.addr[7:5];
      if (r.kind == `XT_CYC_MEMR && r.addr[19:16] == 4'hF) e.rom_sel = 8'h01 << r.addr[15:13];
      if (!io && r.addr[19:18] == 2'b00) e.ram_sel = 4'h1 << r.addr[17:16];
      e.hit = io && (r.addr == `XT_PORT_CTRL || r.addr == `XT_PORT_STAT ||
                     r.addr == `XT_PORT_NMI);
      if (r.kind == `XT_CYC_IOR) begin
         if (r.addr == `XT_PORT_CTRL) e.rdata = m_ctrl;
         else if (r.addr == `XT_PORT_STAT) e.rdata = {m_par, m_chk, timer2_out_i, 5'b0};
         else if (r.addr == `XT_PORT_NMI) e.rdata = {m_allow, 7'b0};
      end
      return e;
   endfunction

   function automatic void update_model(input bus_req_t r);
      if (r.kind == `XT_CYC_IOW && r.addr == `XT_PORT_CTRL) m_ctrl = r.wdata;
      if (r.kind == `XT_CYC_IOW && r.addr == `XT_PORT_NMI) m_allow = r.wdata[7];
      if (m_ctrl[4]) m_par = 1'b0;  // enable high keeps the latch clear
      if (m_ctrl[5]) m_chk = 1'b0;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("Fail %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #DRIVE_DLY;
      end
   endtask

   // present one request and hold it until accepted
   task automatic send_req(input bus_req_t r);
      int   n;
      logic taken;
      taken       = 1'b0;
      req_valid_i = 1'b1;
      req_i       = r;
      for (n = 0; n < TIMEOUT && !taken; n++) begin
         @(negedge clk);
         taken = req_ready_o;  // stable until the next edge
         idle(1);
      end
      req_valid_i = 1'b0;
      if (!taken) begin
         timeouts++;
         $display("timeout: request to address %h was never accepted", r.addr);
      end
   endtask

   task automatic wait_drain();
      int n;
      for (n = 0; n < TIMEOUT && exp_count > 0; n++) idle(1);
      if (exp_count > 0) begin
         timeouts++;
         $display("timeout: %0d responses still missing", exp_count);
      end
   endtask

   task automatic do_cycle(input cyc_kind_t kind, input addr_t addr, input data_t wdata);
      bus_req_t r;
      r.kind  = kind;
      r.addr  = addr;
      r.wdata = wdata;
      send_req(r);
      wait_drain();
   endtask

   // one-cycle pulse on parity_err_i or io_ch_ck_i
   task automatic pulse_error(input logic ch_check);
      parity_err_i = !ch_check;
      io_ch_ck_i   = ch_check;
      idle(1);
      parity_err_i = 1'b0;
      io_ch_ck_i   = 1'b0;
      if (ch_check && !m_ctrl[5]) m_chk = 1'b1;
      if (!ch_check && !m_ctrl[4]) m_par = 1'b1;
   endtask

   // mode 0 i/o only, 1 memory only, 2 mixed with back-pressure and gaps
   task automatic run_random(input int mode, input int n);
      bus_req_t r;
      int       i;
      bp_on = (mode == 2);
      for (i = 0; i < n; i++) begin
         r.kind  = $random(seed);
         r.addr  = $random(seed);
         r.wdata = $random(seed);
         if (mode < 2) r.kind[1] = mode[0];
         if (!r.kind[1] && i % 4 != 0) r.addr[19:10] = '0;  // mostly real ports
         if (!r.kind[1] && i % 16 == 5) begin
            r.addr = (i % 3 == 0) ? `XT_PORT_CTRL :
                     (i % 3 == 1) ? `XT_PORT_STAT : `XT_PORT_NMI;
         end
         if (r.kind[1] && i % 3 == 0) r.addr[19:16] = 4'hF;  // rom area
         if (r.kind[1] && i % 3 == 1) r.addr[19:18] = 2'b00;  // ram area
         send_req(r);
         if (mode == 2) idle($random(seed) & 3);
      end
      bp_on       = 1'b0;
      rsp_ready_i = 1'b1;
      wait_drain();
   endtask

   // response ready drawn ahead of the request inputs of the same cycle
   always @(posedge clk) begin
      #(DRIVE_DLY / 2);
      if (bp_on) rsp_ready_i = ($random(seed) % 2 != 0);
   end

   // handshakes seen half a cycle before the edge that completes them
   always @(negedge clk) begin
      if (reset_n) begin
         if (rsp_valid_o && rsp_ready_i) begin
            if (exp_q.size() > 0) void'(exp_q.pop_front());
            last_rsp = rsp_o;
            rsp_count++;
         end
         if (req_valid_i && req_ready_o) begin
            exp_q.push_back(predict_response(req_i));
            update_model(req_i);
            acc_count++;
         end
         exp_count = exp_q.size();
         exp_head  = (exp_count > 0) ? exp_q[0] : '0;
      end
   end

   rsp_expected_a: assert property (@(negedge clk) disable iff (!reset_n)
      rsp_valid_o |-> exp_count > 0)
      else begin
         errors++;
         $display("response appeared with no request pending");
      end

   rsp_value_a: assert property (@(negedge clk) disable iff (!reset_n)
      (rsp_valid_o && rsp_ready_i) |-> rsp_o == exp_head)
      else begin
         errors++;
         $display("Fail rsp_o: got %h expected %h", $sampled(rsp_o), $sampled(exp_head));
      end

   initial begin
      int    k;
      int    t;
      data_t wval;
      errors       = 0;
      timeouts     = 0;
      acc_count    = 0;
      rsp_count    = 0;
      bp_on        = 1'b0;
      m_ctrl       = '0;
      m_allow      = 1'b0;
      m_par        = 1'b0;
      m_chk        = 1'b0;
      reset_n      = 1'b0;
      req_valid_i  = 1'b0;
      req_i        = '0;
      rsp_ready_i  = 1'b1;
      parity_err_i = 1'b0;
      io_ch_ck_i   = 1'b0;
      timer2_out_i = 1'b0;
      repeat (8) @(posedge clk);
      #DRIVE_DLY;
      reset_n = 1'b1;
      check_value("req_ready_o", req_ready_o, 1'b1);
      check_value("rsp_valid_o", rsp_valid_o, 1'b0);
      check_value("nmi_o", nmi_o, 1'b0);
      check_value("tim2_gate_o", tim2_gate_o, 1'b0);
      check_value("spkr_o", spkr_o, 1'b0);

      run_random(0, 200);  // i/o decode
      run_random(1, 200);  // memory decode

      // control port readback, timer-2 gate and speaker
      for (k = 0; k < 3; k++) begin
         wval = (k == 0) ? 8'hC3 : (k == 1) ? 8'h01 : 8'h02;
         do_cycle(`XT_CYC_IOW, `XT_PORT_CTRL, wval);
         do_cycle(`XT_CYC_IOR, `XT_PORT_CTRL, 8'h00);
         check_value("rdata", last_rsp.rdata, wval);
         check_value("tim2_gate_o", tim2_gate_o, wval[0]);
         for (t = 0; t < 4; t++) begin
            timer2_out_i = t[0];
            idle(1);
            check_value("spkr_o", spkr_o, t[0] & wval[1]);
         end
      end

      // parity latch, channel check latch, then parity with nmi disallowed
      timer2_out_i = 1'b0;
      do_cycle(`XT_CYC_IOW, `XT_PORT_NMI, 8'h80);
      for (k = 0; k < 3; k++) begin
         if (k == 2) do_cycle(`XT_CYC_IOW, `XT_PORT_NMI, 8'h00);
         do_cycle(`XT_CYC_IOW, `XT_PORT_CTRL, 8'h00);  // both checks on
         pulse_error(k == 1);
         check_value("nmi_o", nmi_o, k != 2);
         do_cycle(`XT_CYC_IOR, `XT_PORT_STAT, 8'h00);
         check_value("status rdata", last_rsp.rdata, (k == 1) ? 8'h40 : 8'h80);
         do_cycle(`XT_CYC_IOW, `XT_PORT_CTRL, (k == 1) ? 8'h20 : 8'h10);
         check_value("nmi_o", nmi_o, 1'b0);
      end

      run_random(2, 300);  // back-pressure
      check_value("response count", rsp_count, acc_count);

      $display("requests %0d, responses %0d, errors %0d, timeouts %0d",
               acc_count, rsp_count, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== xt_glue.f ====
+incdir+logic
logic/xt_bus_pkg.sv
logic/xt_decode_pkg.sv
logic/cycle_intake.sv
logic/address_decoder.sv
logic/system_ctrl.sv
logic/response_stage.sv
logic/xt_glue_top.sv
sim/xt_glue_tb.sv
